// File: src/fm_pkg.sv
package fm_pkg;

	// Six FM channels, three per register part
	parameter int num_ch = 6;

	// One register write as seen by the register block
	typedef struct packed {
		logic       part;
		logic [7:0] reg_addr;
		logic [7:0] data;
	} reg_write_t;

	// Timer level settings from registers 0x24..0x27
	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       run_a;
		logic       run_b;
		logic       irq_en_a;
		logic       irq_en_b;
	} timer_cfg_t;

	// Single-cycle flag clear requests
	typedef struct packed {
		logic clr_a;
		logic clr_b;
	} timer_clr_t;

	// Channel frequency as used by the phase generator
	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
	} chan_freq_t;

	// Read-back byte, busy in bit 7
	typedef struct packed {
		logic       busy;
		logic [4:0] rsvd;
		logic       flag_b;
		logic       flag_a;
	} status_t;

endpackage

// File: src/fm_bus_if.sv
`timescale 1ns/1ps

module fm_bus_if import fm_pkg::*; #(
	parameter int busy_cycles = 32
) (
	input  logic       clk_int,
	input  logic       rst,
	input  logic [7:0] din,
	input  logic [1:0] addr,
	input  logic       cs_n,
	input  logic       wr_n,
	input  logic       flag_a,
	input  logic       flag_b,
	output logic       reg_wr,
	output reg_write_t reg_data,
	output status_t    dout
);

	localparam int busy_w = $clog2(busy_cycles + 1);

	// Captured bus access
	logic       acc_s;
	logic [7:0] din_s;
	logic [1:0] addr_s;

	// Register address per part
	logic [7:0] addr_latch [2];

	logic [busy_w-1:0] busy_cnt;
	logic              data_wr;

	always_ff @(posedge clk_int) begin
		if (rst) begin
			acc_s <= 1'b0;
		end else begin
			acc_s <= ~cs_n & ~wr_n;
		end
		din_s  <= din;
		addr_s <= addr;
	end

	// addr_s[0] set means the data port
	assign data_wr = acc_s & addr_s[0];

	always_ff @(posedge clk_int) begin
		if (rst) begin
			addr_latch[0] <= '0;
			addr_latch[1] <= '0;
			reg_wr        <= 1'b0;
		end else begin
			reg_wr <= data_wr;
			if (acc_s && !addr_s[0]) begin
				addr_latch[addr_s[1]] <= din_s;
			end
		end
		reg_data.part     <= addr_s[1];
		reg_data.reg_addr <= addr_latch[addr_s[1]];
		reg_data.data     <= din_s;
	end

	// Busy holds for busy_cycles cycles after each data write
	always_ff @(posedge clk_int) begin
		if (rst) begin
			busy_cnt <= '0;
			dout     <= '0;
		end else begin
			if (data_wr) begin
				busy_cnt <= busy_w'(busy_cycles);
			end else if (busy_cnt != '0) begin
				busy_cnt <= busy_cnt - 1'b1;
			end
			dout.busy   <= data_wr | (busy_cnt > 1);
			dout.rsvd   <= '0;
			dout.flag_b <= flag_b;
			dout.flag_a <= flag_a;
		end
	end

endmodule

// File: src/fm_mmr.sv
`timescale 1ns/1ps

module fm_mmr import fm_pkg::*; (
	input  logic                     clk_int,
	input  logic                     rst,
	input  logic                     reg_wr,
	input  reg_write_t               reg_data,
	output timer_cfg_t               tcfg,
	output timer_clr_t               tclr,
	output chan_freq_t [num_ch-1:0]  freq
);

	logic [1:0] offset;
	logic       offset_ok;
	logic       fnum_hi_wr;
	logic       fnum_lo_wr;
	logic       timer_wr;
	logic [2:0] ch_sel;

	// Block and fnum high bits wait here for the low write
	logic [2:0] hold_block;
	logic [2:0] hold_fhi;

	assign offset    = reg_data.reg_addr[1:0];
	assign offset_ok = offset != 2'd3;

	// 0xA4..0xA6 and 0xA0..0xA2, either part
	assign fnum_hi_wr = reg_wr && offset_ok && reg_data.reg_addr[7:2] == 6'b1010_01;
	assign fnum_lo_wr = reg_wr && offset_ok && reg_data.reg_addr[7:2] == 6'b1010_00;

	// Timer registers live in part 0 only
	assign timer_wr = reg_wr && !reg_data.part;

	assign ch_sel = reg_data.part ? 3'd3 + {1'b0, offset} : {1'b0, offset};

	always_ff @(posedge clk_int) begin
		if (rst) begin
			tcfg <= '0;
			tclr <= '0;
		end else begin
			// Clear pulses last one cycle
			tclr <= '0;
			if (timer_wr) begin
				case (reg_data.reg_addr)
					8'h24: begin
						tcfg.value_a[9:2] <= reg_data.data;
					end
					8'h25: begin
						tcfg.value_a[1:0] <= reg_data.data[1:0];
					end
					8'h26: begin
						tcfg.value_b <= reg_data.data;
					end
					8'h27: begin
						tcfg.run_a    <= reg_data.data[0];
						tcfg.run_b    <= reg_data.data[1];
						tcfg.irq_en_a <= reg_data.data[2];
						tcfg.irq_en_b <= reg_data.data[3];
						tclr.clr_a    <= reg_data.data[4];
						tclr.clr_b    <= reg_data.data[5];
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Frequency table
	always_ff @(posedge clk_int) begin
		if (rst) begin
			hold_block <= '0;
			hold_fhi   <= '0;
			freq       <= '0;
		end else begin
			if (fnum_hi_wr) begin
				hold_block <= reg_data.data[5:3];
				hold_fhi   <= reg_data.data[2:0];
			end
			if (fnum_lo_wr) begin
				freq[ch_sel].fnum  <= {hold_fhi, reg_data.data};
				freq[ch_sel].block <= hold_block;
			end
		end
	end

endmodule

// File: src/fm_timers.sv
`timescale 1ns/1ps

module fm_timers import fm_pkg::*; #(
	parameter int tick_div = 72
) (
	input  logic       clk_int,
	input  logic       rst,
	input  timer_cfg_t tcfg,
	input  timer_clr_t tclr,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq_n
);

	localparam int pre_w = $clog2(tick_div + 1);

	logic [pre_w-1:0] pre_cnt;
	logic [3:0]       div16;
	logic             tick_a;
	logic             tick_b;

	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic       run_a_d;
	logic       run_b_d;
	logic       ovf_a;
	logic       ovf_b;

	// Free-running prescaler, timer B gets every 16th tick
	always_ff @(posedge clk_int) begin
		if (rst) begin
			pre_cnt <= '0;
			div16   <= '0;
		end else begin
			if (tick_a) begin
				pre_cnt <= '0;
				div16   <= div16 + 1'b1;
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

	assign tick_a = pre_cnt == pre_w'(tick_div - 1);
	assign tick_b = tick_a && div16 == 4'hf;

	assign ovf_a = tcfg.run_a && run_a_d && tick_a && cnt_a == 10'h3ff;
	assign ovf_b = tcfg.run_b && run_b_d && tick_b && cnt_b == 8'hff;

	always_ff @(posedge clk_int) begin
		if (rst) begin
			run_a_d <= 1'b0;
			run_b_d <= 1'b0;
			cnt_a   <= '0;
			cnt_b   <= '0;
		end else begin
			run_a_d <= tcfg.run_a;
			run_b_d <= tcfg.run_b;
			// Load on run rising edge and on overflow
			if ((tcfg.run_a && !run_a_d) || ovf_a) begin
				cnt_a <= tcfg.value_a;
			end else if (tcfg.run_a && tick_a) begin
				cnt_a <= cnt_a + 1'b1;
			end
			if ((tcfg.run_b && !run_b_d) || ovf_b) begin
				cnt_b <= tcfg.value_b;
			end else if (tcfg.run_b && tick_b) begin
				cnt_b <= cnt_b + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_int) begin
		if (rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (tclr.clr_a) begin
				flag_a <= 1'b0;
			end else if (ovf_a && tcfg.irq_en_a) begin
				flag_a <= 1'b1;
			end
			if (tclr.clr_b) begin
				flag_b <= 1'b0;
			end else if (ovf_b && tcfg.irq_en_b) begin
				flag_b <= 1'b1;
			end
		end
	end

	assign irq_n = ~(flag_a | flag_b);

endmodule

// File: src/fm_pg.sv
`timescale 1ns/1ps

module fm_pg import fm_pkg::*; (
	input  logic                    clk_int,
	input  logic                    rst,
	input  chan_freq_t [num_ch-1:0] freq,
	output logic [19:0]             phase_out,
	output logic [2:0]              ch,
	output logic                    zero
);

	logic [2:0]  slot;
	logic [19:0] phase [num_ch];
	logic [19:0] inc;
	logic [19:0] phase_nx;

	// Half of fnum shifted by block
	assign inc      = ({9'd0, freq[slot].fnum} << freq[slot].block) >> 1;
	assign phase_nx = phase[slot] + inc;

	always_ff @(posedge clk_int) begin
		if (rst) begin
			slot <= '0;
		end else if (slot == 3'(num_ch - 1)) begin
			slot <= '0;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	// One accumulator updated per clock
	always_ff @(posedge clk_int) begin
		if (rst) begin
			for (int i = 0; i < num_ch; i++) begin
				phase[i] <= '0;
			end
			phase_out <= '0;
			ch        <= '0;
			zero      <= 1'b0;
		end else begin
			phase[slot] <= phase_nx;
			phase_out   <= phase_nx;
			ch          <= slot;
			zero        <= slot == 3'd0;
		end
	end

endmodule

// File: src/fm_chip.sv
`timescale 1ns/1ps

module fm_chip import fm_pkg::*; #(
	parameter int tick_div    = 72,
	parameter int busy_cycles = 32
) (
	input  logic        clk_int,
	input  logic        rst,
	input  logic [7:0]  din,
	input  logic [1:0]  addr,
	input  logic        cs_n,
	input  logic        wr_n,
	output status_t     dout,
	output logic        irq_n,
	output logic [19:0] phase_out,
	output logic [2:0]  ch,
	output logic        zero
);

	logic                    reg_wr;
	reg_write_t              reg_data;
	timer_cfg_t              tcfg;
	timer_clr_t              tclr;
	chan_freq_t [num_ch-1:0] freq;
	logic                    flag_a;
	logic                    flag_b;

	fm_bus_if #(
		.busy_cycles(busy_cycles)
	) u_bus_if (
		.clk_int  (clk_int),
		.rst      (rst),
		.din      (din),
		.addr     (addr),
		.cs_n     (cs_n),
		.wr_n     (wr_n),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.reg_wr   (reg_wr),
		.reg_data (reg_data),
		.dout     (dout)
	);

	fm_mmr u_mmr (
		.clk_int  (clk_int),
		.rst      (rst),
		.reg_wr   (reg_wr),
		.reg_data (reg_data),
		.tcfg     (tcfg),
		.tclr     (tclr),
		.freq     (freq)
	);

	fm_timers #(
		.tick_div(tick_div)
	) u_timers (
		.clk_int (clk_int),
		.rst     (rst),
		.tcfg    (tcfg),
		.tclr    (tclr),
		.flag_a  (flag_a),
		.flag_b  (flag_b),
		.irq_n   (irq_n)
	);

	fm_pg u_pg (
		.clk_int   (clk_int),
		.rst       (rst),
		.freq      (freq),
		.phase_out (phase_out),
		.ch        (ch),
		.zero      (zero)
	);

endmodule

// File: testbench/tb_fm_chip.sv
`timescale 1ns/1ps

module tb_fm_chip import fm_pkg::*; ();

	localparam int tick_div    = 4;
	localparam int busy_cycles = 6;

	localparam logic [2:0] op_write  = 3'd0;
	localparam logic [2:0] op_addr   = 3'd1;
	localparam logic [2:0] op_busy   = 3'd2;
	localparam logic [2:0] op_flag   = 3'd3;
	localparam logic [2:0] op_status = 3'd4;
	localparam logic [2:0] op_phase  = 3'd5;

	localparam status_t st_idle = 8'h00;
	localparam status_t st_fa   = 8'h01;
	localparam status_t st_fb   = 8'h02;

	// Timer start values
	localparam logic [9:0] val_a = 10'd1020;
	localparam logic [7:0] val_b = 8'd254;

	// Two edges until run is visible and one more for status
	localparam int flag_lat = 3;

	// One table row, lo and hi are cycle windows or counts
	typedef struct packed {
		logic [2:0] op;
		logic       part;
		logic [7:0] ra;
		logic [7:0] data;
		status_t    exp;
		logic       irq;
		int         lo;
		int         hi;
	} step_t;

	logic        clk_int;
	logic        rst;
	logic [7:0]  din;
	logic [1:0]  addr;
	logic        cs_n;
	logic        wr_n;
	status_t     dout;
	logic        irq_n;
	logic [19:0] phase_out;
	logic [2:0]  ch;
	logic        zero;

	step_t       steps [$];
	integer      seed;
	int          errors = 0;
	int          step_err = 0;
	int          fails = 0;
	int          cycles = 0;
	int          cycle_limit = 1000000;
	int          live_edges = 0;
	logic [10:0] exp_fnum [num_ch];
	logic [2:0]  exp_blk [num_ch];
	logic [5:0]  hold;
	string       op_name [6] = '{"write", "addr", "busy", "flag", "status", "phase"};

	fm_chip #(
		.tick_div    (tick_div),
		.busy_cycles (busy_cycles)
	) u_fm_chip (
		.clk_int   (clk_int),
		.rst       (rst),
		.din       (din),
		.addr      (addr),
		.cs_n      (cs_n),
		.wr_n      (wr_n),
		.dout      (dout),
		.irq_n     (irq_n),
		.phase_out (phase_out),
		.ch        (ch),
		.zero      (zero)
	);

	always #4 clk_int = ~clk_int;

	// Edges since reset release give the expected slot
	always @(posedge clk_int) begin
		cycles = cycles + 1;
		if (rst) begin
			live_edges = 0;
		end else begin
			live_edges = live_edges + 1;
		end
		if (cycles > cycle_limit) begin
			$display("Run stopped after %0d cycles before the step table finished", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic note_error();
		errors++;
		step_err++;
	endtask

	task automatic check_status(input status_t got, input status_t exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t dout expected %02h got %02h", $time, exp, got);
			note_error();
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t irq_n expected %b got %b", $time, exp, got);
			note_error();
		end
	endtask

	task automatic check_phase(input logic [19:0] got, input logic [19:0] exp,
			input logic [2:0] got_ch, input logic [2:0] exp_ch, input logic got_zero);
		if (got !== exp) begin
			$display("MISMATCH t=%0t phase_out expected %05h got %05h", $time, exp, got);
			note_error();
		end
		if (got_ch !== exp_ch) begin
			$display("MISMATCH t=%0t ch expected %0d got %0d", $time, exp_ch, got_ch);
			note_error();
		end
		if (got_zero !== (exp_ch == 3'd0)) begin
			$display("MISMATCH t=%0t zero expected %b got %b", $time, exp_ch == 3'd0, got_zero);
			note_error();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, got);
			note_error();
		end
	endtask

	// Phase step per sample, half of fnum times two to the block
	function automatic logic [19:0] step_inc(input int c);
		int full;
		full = int'(exp_fnum[c]) * (1 << exp_blk[c]);
		return 20'(full / 2);
	endfunction

	function automatic step_t make_step(input logic [2:0] op, input logic part,
			input logic [7:0] ra, input logic [7:0] data, input status_t exp,
			input logic irq, input int lo, input int hi);
		return '{op, part, ra, data, exp, irq, lo, hi};
	endfunction

	function automatic void add_write(input logic part, input logic [7:0] ra,
			input logic [7:0] data);
		steps.push_back(make_step(op_write, part, ra, data, st_idle, 1'b1, 0, 4));
	endfunction

	function automatic void add_check(input logic [2:0] op, input status_t exp,
			input logic irq, input int lo, input int hi);
		steps.push_back(make_step(op, 1'b0, 8'h00, 8'h00, exp, irq, lo, hi));
	endfunction

	task automatic bus_cycle(input logic [1:0] a, input logic [7:0] d);
		@(negedge clk_int);
		cs_n = 1'b0;
		wr_n = 1'b0;
		addr = a;
		din  = d;
	endtask

	task automatic bus_idle();
		@(negedge clk_int);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	// Address then data port, and track the frequency registers
	task automatic reg_write(input logic part, input logic [7:0] ra, input logic [7:0] data);
		int chn;
		bus_cycle({part, 1'b0}, ra);
		bus_cycle({part, 1'b1}, data);
		bus_idle();
		chn = 3 * int'(part) + int'(ra[1:0]);
		if (ra[7:2] == 6'b101001 && ra[1:0] != 2'd3) begin
			hold = data[5:0];
		end
		if (ra[7:2] == 6'b101000 && ra[1:0] != 2'd3) begin
			exp_fnum[chn] = {hold[2:0], data};
			exp_blk[chn]  = hold[5:3];
		end
	endtask

	task automatic measure_busy();
		int waited;
		int n_high;
		waited = 0;
		n_high = 0;
		while (!dout.busy && waited < 4) begin
			@(negedge clk_int);
			waited++;
		end
		while (dout.busy && n_high < 40) begin
			n_high++;
			@(negedge clk_int);
		end
		check_count("busy cycles", n_high, busy_cycles);
	endtask

	task automatic wait_flag(input step_t s);
		int   k;
		logic seen;
		k    = 0;
		seen = 1'b0;
		while (!seen && k < s.hi) begin
			@(negedge clk_int);
			k++;
			seen = (dout.flag_a & s.exp.flag_a) | (dout.flag_b & s.exp.flag_b);
		end
		if (!seen) begin
			$display("Timer flag did not appear within %0d cycles", s.hi);
			note_error();
		end else begin
			if (k < s.lo) begin
				$display("Timer flag appeared after %0d cycles, before the %0d limit", k, s.lo);
				note_error();
			end
			check_status(dout, s.exp);
			check_irq(irq_n, s.irq);
		end
	endtask

	task automatic hold_status(input step_t s);
		repeat (s.hi) begin
			@(negedge clk_int);
			check_status(dout, s.exp);
			check_irq(irq_n, s.irq);
		end
	endtask

	// First visit of each channel gives the baseline phase
	task automatic track_phase(input step_t s);
		logic [19:0] last [num_ch];
		logic        seen_ch [num_ch];
		logic [19:0] exp_ph;
		logic [2:0]  exp_ch;
		int          c;
		repeat (2) @(negedge clk_int);
		for (int i = 0; i < num_ch; i++) begin
			seen_ch[i] = 1'b0;
		end
		repeat (s.hi) begin
			@(negedge clk_int);
			exp_ch = 3'((live_edges - 1) % num_ch);
			c      = int'(exp_ch);
			exp_ph = seen_ch[c] ? last[c] + step_inc(c) : phase_out;
			check_phase(phase_out, exp_ph, ch, exp_ch, zero);
			last[c]    = phase_out;
			seen_ch[c] = 1'b1;
		end
	endtask

	initial begin
		step_t s;
		int    fnum;
		int    blk;
		clk_int = 1'b0;
		rst     = 1'b1;
		cs_n    = 1'b1;
		wr_n    = 1'b1;
		din     = 8'h00;
		addr    = 2'b00;
		seed    = 32'h322f;
		hold    = '0;
		for (int i = 0; i < num_ch; i++) begin
			exp_fnum[i] = '0;
			exp_blk[i]  = '0;
		end
		// Reset state, then an address write that must not set busy
		add_check(op_status, st_idle, 1'b1, 0, 6);
		add_check(op_phase, st_idle, 1'b1, 0, 14);
		steps.push_back(make_step(op_addr, 1'b0, 8'h24, 8'h00, st_idle, 1'b1, 0, 2));
		add_check(op_status, st_idle, 1'b1, 0, 8);
		// Timer A from 1020
		add_write(1'b0, 8'h24, val_a[9:2]);
		add_check(op_busy, st_idle, 1'b1, 0, 45);
		add_write(1'b0, 8'h25, {6'd0, val_a[1:0]});
		add_write(1'b0, 8'h27, 8'h05);
		add_check(op_flag, st_fa, 1'b0,
			(1024 - int'(val_a) - 1) * tick_div + flag_lat,
			(1024 - int'(val_a) + 1) * tick_div + flag_lat);
		// Clear flag A and keep A running without irq_en_a
		add_write(1'b0, 8'h27, 8'h11);
		add_check(op_busy, st_idle, 1'b1, 0, 45);
		add_check(op_status, st_idle, 1'b1, 0, 40);
		// Timer B from 254
		add_write(1'b0, 8'h26, val_b);
		add_write(1'b0, 8'h27, 8'h0a);
		add_check(op_flag, st_fb, 1'b0,
			(256 - int'(val_b) - 1) * 16 * tick_div + flag_lat,
			(256 - int'(val_b) + 1) * 16 * tick_div + flag_lat);
		add_write(1'b0, 8'h27, 8'h20);
		add_check(op_busy, st_idle, 1'b1, 0, 45);
		add_check(op_status, st_idle, 1'b1, 0, 8);
		// Random frequencies in both parts
		for (int c = 0; c < num_ch; c++) begin
			fnum = $random(seed) & 32'h7ff;
			blk  = $random(seed) & 32'h7;
			add_write(c >= 3, 8'ha4 + 8'(c % 3), {2'b00, blk[2:0], fnum[10:8]});
			add_write(c >= 3, 8'ha0 + 8'(c % 3), fnum[7:0]);
		end
		add_check(op_phase, st_idle, 1'b1, 0, 14);
		// Channel 0 keeps its step until the low write lands
		fnum = $random(seed) & 32'h7ff;
		blk  = $random(seed) & 32'h7;
		add_write(1'b0, 8'ha4, {2'b00, blk[2:0], fnum[10:8]});
		add_check(op_phase, st_idle, 1'b1, 0, 14);
		add_write(1'b0, 8'ha0, fnum[7:0]);
		add_check(op_phase, st_idle, 1'b1, 0, 14);
		cycle_limit = 200;
		foreach (steps[i]) begin
			cycle_limit += steps[i].hi;
		end
		repeat (3) @(posedge clk_int);
		@(negedge clk_int);
		rst = 1'b0;
		foreach (steps[i]) begin
			s        = steps[i];
			step_err = 0;
			case (s.op)
				op_write: reg_write(s.part, s.ra, s.data);
				op_addr: begin
					bus_cycle({s.part, 1'b0}, s.ra);
					bus_idle();
				end
				op_busy: measure_busy();
				op_flag: wait_flag(s);
				op_status: hold_status(s);
				default: track_phase(s);
			endcase
			if (step_err != 0) begin
				fails++;
			end
			$display("step %0d %s: %s", i, op_name[s.op], (step_err != 0) ? "FAIL" : "PASS");
		end
		$display("%0d steps run, %0d failed, %0d errors", steps.size(), fails, errors);
		if (fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: flist.f
src/fm_pkg.sv
src/fm_bus_if.sv
src/fm_mmr.sv
src/fm_timers.sv
src/fm_pg.sv
src/fm_chip.sv
testbench/tb_fm_chip.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result from sim.log

verilator --binary --timing -f flist.f --top-module tb_fm_chip -o tb_fm_chip > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_fm_chip > sim.log 2>&1 || { echo "Simulation did not run, see sim.log"; exit 1; }

grep -q "Test failures found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "FAIL, no result in sim.log"; exit 1; }
echo "PASS"
